// ==== list.f ====
rtl/ppBridgePkg.sv
rtl/serialLinkIf.sv
rtl/strobeSync.sv
rtl/hostParser.sv
rtl/serialShifter.sv
rtl/indexRegFile.sv
rtl/ppBridgeTop.sv
verification/ppBridgeTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module ppBridgeTb
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

out=$(./obj_dir/VppBridgeTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if echo "$out" | grep -q "^Finished with no errors$"; then
        exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verification/ppBridgeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppBridgeTb;
        import ppBridgePkg::*;

        localparam int cycleLimit = 20000;

        logic             ICK;
        logic             RST;
        logic             nStb;
        logic             nAufd;
        logic [7:0]       hostDataIn;
        logic [7:0]       hostDataOut;
        logic             hostDataOe;
        logic             busy;

        // reference copy of the register file.
        logic [wordW-1:0] refMem [regCount];
        logic [idxW-1:0]  curIdx;
        logic             serving;
        integer           seed;
        int               cycleCount = 0;

        ppBridgeTop dut_i (
                .ICK, .RST, .nStb, .nAufd, .hostDataIn,
                .hostDataOut, .hostDataOe, .busy
        );

        initial begin
                ICK = 1'b0;
                forever #4 ICK = ~ICK;
        end

        task automatic reportFailure(input string msg);
                $display("%s", msg);
                $display("Finished with errors");
                $fatal(1, "simulation stopped");
        endtask

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                assert (actual === expected) else
                        reportFailure($sformatf(
                                "** Error at %0t ns: %s expected 0x%08h, actual 0x%08h",
                                $time, name, expected, actual));
        endtask

        task automatic stepCycles(input int n);
                repeat (n) @(posedge ICK);
                #1;
        endtask

        task automatic waitBusy(input logic level, input int limit);
                int waited;
                waited = 0;
                while ((busy !== level) && (waited < limit)) begin
                        stepCycles(1);
                        waited++;
                end
                assert (busy === level) else
                        reportFailure($sformatf("busy did not go %s within %0d cycles",
                                                level ? "high" : "low", limit));
        endtask

        // mask of the bits a frame of len+1 bits carries.
        function automatic logic [31:0] lenMask(input logic [4:0] len);
                logic [32:0] m;
                m = (33'd1 << (len + 6'd1)) - 33'd1;
                return m[31:0];
        endfunction

        task automatic doStrobeByte(input logic [7:0] data);
                hostDataIn = data;
                nAufd = 1'b0;
                stepCycles(4);
                nAufd = 1'b1;
                stepCycles(4);
        endtask

        task automatic sendCommand(input logic [7:0] cmd);
                checkValue("busy", 0, busy);
                hostDataIn = cmd;
                nStb = 1'b0;
                stepCycles(4);
                waitBusy(1'b1, 20);
                doStrobeByte(cmd);
        endtask

        task automatic selectIndex(input logic [3:0] idx);
                sendCommand({4'b0000, idx});
                nStb = 1'b1;
                stepCycles(4);
                waitBusy(1'b0, 100);
                curIdx = idx;
        endtask

        task automatic writeWord(input logic [4:0] len, input logic [31:0] word);
                sendCommand({3'b100, len});
                for (int k = 0; k < 4; k++)
                        doStrobeByte(word[8*k +: 8]);
                nStb = 1'b1;
                stepCycles(4);
                waitBusy(1'b0, 100);
                refMem[curIdx] = word & lenMask(len);
        endtask

        task automatic readWord(input logic [4:0] len, output logic [31:0] got);
                logic [31:0] expected;
                int          nBytes;
                expected = refMem[curIdx] & lenMask(len);
                nBytes = len / 8 + 1;
                got = '0;
                sendCommand({3'b110, len});
                // busy drops once the read word is ready.
                waitBusy(1'b0, 100);
                for (int n = 0; n < nBytes; n++) begin
                        serving = 1'b1;
                        nAufd = 1'b0;
                        stepCycles(4);
                        checkValue("hostDataOe", 1, hostDataOe);
                        checkValue("busy", 0, busy);
                        checkValue($sformatf("hostDataOut byte %0d", n),
                                   expected[8*n +: 8], hostDataOut);
                        got[8*n +: 8] = hostDataOut;
                        nAufd = 1'b1;
                        stepCycles(4);
                        checkValue("hostDataOe", 0, hostDataOe);
                        serving = 1'b0;
                end
                nStb = 1'b1;
                stepCycles(4);
                checkValue("busy", 0, busy);
        endtask

        task automatic testResetState();
                logic [31:0] got;
                checkValue("busy", 0, busy);
                checkValue("hostDataOe", 0, hostDataOe);
                readWord(5'd31, got);
                checkValue("reset read of index 0", 0, got);
        endtask

        task automatic testRoundTrip();
                logic [31:0] w;
                logic [31:0] got;
                w = $random(seed);
                selectIndex(4'd5);
                writeWord(5'd31, w);
                readWord(5'd31, got);
                checkValue("round trip word", w, got);
        endtask

        task automatic testShortWrite();
                logic [31:0] w;
                logic [31:0] got;
                // upper bits set so the clearing shows.
                w = $random(seed) | 32'hF000_0000;
                selectIndex(4'd9);
                writeWord(5'd11, w);
                readWord(5'd31, got);
                checkValue("masked word", w & 32'h0000_0FFF, got);
        endtask

        task automatic testShortRead();
                logic [31:0] got;
                selectIndex(4'd5);
                readWord(5'd7, got);
                checkValue("short read low byte", refMem[5][7:0], got);
        endtask

        task automatic testIndexIsolation();
                int          order [regCount];
                int          j;
                int          tmp;
                logic        fresh;
                logic [31:0] w;
                logic [31:0] got;
                for (int i = 0; i < regCount; i++) begin
                        fresh = 1'b0;
                        while (!fresh) begin
                                w = $random(seed);
                                fresh = 1'b1;
                                for (int k = 0; k < i; k++)
                                        if (refMem[k] == w)
                                                fresh = 1'b0;
                        end
                        selectIndex(i[3:0]);
                        writeWord(5'd31, w);
                        order[i] = i;
                end
                // shuffle the read order.
                for (int i = regCount - 1; i > 0; i--) begin
                        j = $unsigned($random(seed)) % (i + 1);
                        tmp = order[i];
                        order[i] = order[j];
                        order[j] = tmp;
                end
                for (int i = 0; i < regCount; i++) begin
                        selectIndex(order[i][3:0]);
                        readWord(5'd31, got);
                        checkValue($sformatf("index %0d word", order[i]), refMem[order[i]], got);
                end
        endtask

        task automatic testBusyProtocol();
                logic [31:0] w;
                logic [31:0] got;
                checkValue("busy", 0, busy);
                checkValue("hostDataOe", 0, hostDataOe);
                hostDataIn = 8'h03;
                nStb = 1'b0;
                stepCycles(1);
                // still inside the synchronizer delay.
                checkValue("busy", 0, busy);
                waitBusy(1'b1, 8);
                doStrobeByte(8'h03);
                nStb = 1'b1;
                stepCycles(4);
                waitBusy(1'b0, 100);
                curIdx = 4'd3;
                w = $random(seed);
                writeWord(5'd15, w);
                checkValue("busy", 0, busy);
                readWord(5'd15, got);
                checkValue("half word", w & 32'h0000_FFFF, got);
        endtask

        // hostDataOe only belongs to a read byte strobe.
        always @(negedge ICK) begin
                if (RST === 1'b0) begin
                        assert (!hostDataOe || serving) else
                                reportFailure("hostDataOe went high outside a read byte strobe");
                        assert (!(serving && busy)) else
                                reportFailure("busy was high while read bytes were served");
                end
        end

        always @(posedge ICK) begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= cycleLimit)
                        reportFailure($sformatf("timeout, run exceeded %0d cycles", cycleLimit));
        end

        initial begin
                seed = 37817;
                RST = 1'b1;
                nStb = 1'b1;
                nAufd = 1'b1;
                hostDataIn = 8'h00;
                serving = 1'b0;
                curIdx = '0;
                for (int i = 0; i < regCount; i++)
                        refMem[i] = '0;
                stepCycles(4);
                RST = 1'b0;
                stepCycles(2);
                testResetState();
                testRoundTrip();
                testShortWrite();
                testShortRead();
                testIndexIsolation();
                testBusyProtocol();
                $display("Finished with no errors");
                $finish;
        end
endmodule

`default_nettype wire

// ==== rtl/ppBridgeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppBridgeTop (
        input  logic       ICK,
        input  logic       RST,
        input  logic       nStb,
        input  logic       nAufd,
        input  logic [7:0] hostDataIn,
        output logic [7:0] hostDataOut,
        output logic       hostDataOe,
        output logic       busy
);
        import ppBridgePkg::*;

        logic             nStbS;
        logic             nAufdS;
        logic             jobValid;
        logic             jobReady;
        logic             jobDone;
        serialJobT        job;
        logic [wordW-1:0] readWord;

        serialLinkIf link ();

        strobeSync stbSync (.ICK, .RST, .pinN(nStb), .syncN(nStbS));

        strobeSync aufdSync (.ICK, .RST, .pinN(nAufd), .syncN(nAufdS));

        hostParser parser (
                .ICK, .RST,
                .nStbS, .nAufdS, .hostDataIn,
                .jobReady, .jobDone, .readWord,
                .job, .jobValid,
                .hostDataOut, .hostDataOe, .busy
        );

        serialShifter shifter (
                .ICK, .RST,
                .job, .jobValid,
                .jobReady, .jobDone, .readWord,
                .link(link.bridge)
        );

        indexRegFile regFile (.ICK, .RST, .link(link.target));
endmodule

`default_nettype wire

// ==== rtl/indexRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module indexRegFile (
        input  logic        ICK,
        input  logic        RST,
        serialLinkIf.target link
);
        import ppBridgePkg::*;

        logic [wordW-1:0]   regs [regCount];
        logic [idxW-1:0]    idxReg;
        // counts preamble and data bits, up to 37.
        logic [cmdLenW:0]   bitCnt;
        logic [cmdLenW-1:0] rdPtr;
        logic               inPre;

        assign inPre = (link.frameOp == opRead) && (bitCnt < (cmdLenW + 1)'(cmdLenW));

        // read bits go out from len downwards.
        assign link.bitToHost = regs[idxReg][rdPtr];

        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        bitCnt <= '0;
                        rdPtr  <= '0;
                        idxReg <= '0;
                        for (int i = 0; i < regCount; i++)
                                regs[i] <= '0;
                end else if (!link.frameActive) begin
                        bitCnt <= '0;
                end else if (link.bitValid) begin
                        bitCnt <= bitCnt + 1'b1;
                        case (link.frameOp)
                        opSetIndex: idxReg <= {link.bitToTarget, idxReg[idxW-1:1]};
                        opWrite: begin
                                // first bit clears the rest of the word.
                                if (bitCnt == '0)
                                        regs[idxReg] <= {{(wordW - 1){1'b0}}, link.bitToTarget};
                                else
                                        regs[idxReg][bitCnt[cmdLenW-1:0]] <= link.bitToTarget;
                        end
                        opRead: begin
                                if (inPre)
                                        rdPtr <= {link.bitToTarget, rdPtr[cmdLenW-1:1]};
                                else
                                        rdPtr <= rdPtr - 1'b1;
                        end
                        default: ;
                        endcase
                end
        end

        // a set-index frame carries exactly four bits.
        assert property (@(posedge ICK) disable iff (RST)
                $fell(link.frameActive) && (link.frameOp == opSetIndex) |-> (bitCnt == idxBits))
                else $error("set-index frame did not carry four bits");
endmodule

`default_nettype wire

// ==== rtl/serialShifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module serialShifter (
        input  logic                           ICK,
        input  logic                           RST,
        input  ppBridgePkg::serialJobT         job,
        input  logic                           jobValid,
        output logic                           jobReady,
        output logic                           jobDone,
        output logic [ppBridgePkg::wordW-1:0]  readWord,
        serialLinkIf.bridge                    link
);
        import ppBridgePkg::*;

        typedef enum logic [2:0] {
                shIdle,
                shLead,
                shPre,
                shData,
                shDone
        } shiftStateT;

        shiftStateT         state;
        serialJobT          jobR;
        logic [cmdLenW-1:0] bitCnt;
        logic [cmdLenW-1:0] lenSh;
        logic [cmdLenW-1:0] lastIdx;
        logic               preLast;
        logic               dataLast;

        assign jobReady = (state == shIdle);
        assign jobDone  = (state == shDone);

        assign link.frameActive = (state == shLead) || (state == shPre) || (state == shData);
        assign link.bitValid    = (state == shPre) || (state == shData);
        assign link.frameOp     = jobR.op;

        // set-index frames always carry four bits.
        assign lastIdx  = (jobR.op == opSetIndex) ? cmdLenW'(idxBits - 1) : jobR.len;
        assign preLast  = (state == shPre) && (bitCnt == cmdLenW'(cmdLenW - 1));
        assign dataLast = (state == shData) && (bitCnt == lastIdx);

        always_comb begin
                link.bitToTarget = 1'b0;
                if (state == shPre)
                        link.bitToTarget = lenSh[0];
                else if ((state == shData) && (jobR.op == opWrite))
                        link.bitToTarget = jobR.word[bitCnt];
                else if ((state == shData) && (jobR.op == opSetIndex))
                        link.bitToTarget = jobR.idx[bitCnt[1:0]];
        end

        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        state  <= shIdle;
                        bitCnt <= '0;
                end else begin
                        case (state)
                        shIdle: if (jobValid) state <= shLead;
                        shLead: begin
                                bitCnt <= '0;
                                // read frames lead with the length preamble.
                                state  <= (jobR.op == opRead) ? shPre : shData;
                        end
                        shPre: begin
                                if (preLast) begin
                                        bitCnt <= '0;
                                        state  <= shData;
                                end else begin
                                        bitCnt <= bitCnt + 1'b1;
                                end
                        end
                        shData: begin
                                if (dataLast)
                                        state <= shDone;
                                else
                                        bitCnt <= bitCnt + 1'b1;
                        end
                        default: state <= shIdle;
                        endcase
                end
        end

        always_ff @(posedge ICK) begin
                if (jobValid && jobReady) begin
                        jobR     <= job;
                        lenSh    <= job.len;
                        readWord <= '0;
                end else begin
                        if (state == shPre)
                                lenSh <= lenSh >> 1;
                        // top bit arrives first, so shift left.
                        if ((state == shData) && (jobR.op == opRead))
                                readWord <= {readWord[wordW-2:0], link.bitToHost};
                end
        end

        // the lead cycle comes before any bit.
        assert property (@(posedge ICK) disable iff (RST)
                $rose(link.frameActive) |-> !link.bitValid)
                else $error("frame started without its lead cycle");

        assert property (@(posedge ICK) disable iff (RST)
                (state == shData) |-> (bitCnt <= lastIdx))
                else $error("bit counter passed the end of the frame");
endmodule

`default_nettype wire

// ==== rtl/hostParser.sv ====
`timescale 1ns/1ps
`default_nettype none

module hostParser (
        input  logic                           ICK,
        input  logic                           RST,
        input  logic                           nStbS,
        input  logic                           nAufdS,
        input  logic [7:0]                     hostDataIn,
        input  logic                           jobReady,
        input  logic                           jobDone,
        input  logic [ppBridgePkg::wordW-1:0]  readWord,
        output ppBridgePkg::serialJobT         job,
        output logic                           jobValid,
        output logic [7:0]                     hostDataOut,
        output logic                           hostDataOe,
        output logic                           busy
);
        import ppBridgePkg::*;

        parserStateT      state;
        parserStateT      nextState;
        bridgeOpT         cmdOp;
        logic [7:0]       cmd;
        logic [wordW-1:0] wrWord;
        logic [wordW-1:0] rdWord;
        logic [2:0]       wrCnt;
        logic [1:0]       rdCnt;
        logic             cmdLatch;
        logic             byteLatch;
        logic             rdUp;
        logic             issue;

        // bit 6 only matters once bit 7 is set.
        assign cmdOp = cmd[7] ? bridgeOpT'(cmd[7:6]) : opSetIndex;

        always_comb begin
                nextState = state;
                case (state)
                stIdle:      if (!nStbS) nextState = stWaitCmd;
                stWaitCmd:   if (!nAufdS) nextState = stDecode;
                stDecode: begin
                        if (nAufdS) begin
                                case (cmdOp)
                                opWrite: nextState = stWrCollect;
                                opRead:  nextState = stRdSerial;
                                default: nextState = stIdxHold;
                                endcase
                        end
                end
                stIdxHold:   if (nStbS) nextState = stSerial;
                stWrCollect: begin
                        if (nStbS)
                                nextState = stSerial;
                        else if (!nAufdS)
                                nextState = stWrByte;
                end
                stWrByte:    if (nAufdS) nextState = stWrCollect;
                stSerial:    if (jobDone) nextState = stIdle;
                stRdSerial:  if (jobDone) nextState = stRdServe;
                stRdServe: begin
                        if (nStbS)
                                nextState = stIdle;
                        else if (!nAufdS)
                                nextState = stRdByte;
                end
                stRdByte:    if (nAufdS) nextState = stRdServe;
                default:     nextState = stIdle;
                endcase
        end

        assign cmdLatch  = (state == stWaitCmd) && !nAufdS;
        assign byteLatch = (state == stWrCollect) && (nextState == stWrByte);
        assign rdUp      = (state == stRdByte) && nAufdS;
        assign issue     = ((nextState == stSerial) && (state != stSerial)) ||
                           ((nextState == stRdSerial) && (state != stRdSerial));

        assign hostDataOe  = (state == stRdByte);
        assign hostDataOut = rdWord[{rdCnt, 3'b000} +: 8];

        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        state    <= stIdle;
                        jobValid <= 1'b0;
                        busy     <= 1'b0;
                        wrCnt    <= '0;
                        rdCnt    <= '0;
                end else begin
                        state <= nextState;
                        if (issue)
                                jobValid <= 1'b1;
                        else if (jobReady)
                                jobValid <= 1'b0;
                        // busy drops while read bytes are served.
                        if ((state == stIdle) && (nextState == stWaitCmd))
                                busy <= 1'b1;
                        else if ((nextState == stIdle) || (nextState == stRdServe))
                                busy <= 1'b0;
                        if (cmdLatch) begin
                                wrCnt <= '0;
                                rdCnt <= '0;
                        end else begin
                                if (byteLatch && (wrCnt != 3'd4))
                                        wrCnt <= wrCnt + 3'd1;
                                if (rdUp)
                                        rdCnt <= rdCnt + 2'd1;
                        end
                end
        end

        always_ff @(posedge ICK) begin
                if (cmdLatch) begin
                        cmd    <= hostDataIn;
                        wrWord <= '0;
                end else if (byteLatch && (wrCnt != 3'd4)) begin
                        wrWord[{wrCnt[1:0], 3'b000} +: 8] <= hostDataIn;
                end
                if (issue)
                        job <= '{op: cmdOp, len: cmd[4:0], idx: cmd[3:0], word: wrWord};
                if ((state == stRdSerial) && jobDone)
                        rdWord <= readWord;
        end

        // a pending job holds until the shifter takes it.
        assert property (@(posedge ICK) disable iff (RST)
                jobValid && !jobReady |=> jobValid && $stable(job))
                else $error("jobValid dropped or job changed before acceptance");

        assert property (@(posedge ICK) disable iff (RST)
                hostDataOe |-> !busy)
                else $error("hostDataOe high while busy");
endmodule

`default_nettype wire

// ==== rtl/strobeSync.sv ====
`timescale 1ns/1ps
`default_nettype none

module strobeSync (
        input  logic ICK,
        input  logic RST,
        input  logic pinN,
        output logic syncN
);
        logic q0;
        logic q1;
        logic held;

        // follow the chain only once two samples agree.
        assign syncN = (q0 == q1) ? q1 : held;

        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        q0   <= 1'b1;
                        q1   <= 1'b1;
                        held <= 1'b1;
                end else begin
                        q0   <= pinN;
                        q1   <= q0;
                        held <= syncN;
                end
        end
endmodule

`default_nettype wire

// ==== rtl/serialLinkIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface serialLinkIf;
        import ppBridgePkg::*;

        logic     frameActive;
        bridgeOpT frameOp;
        logic     bitValid;
        logic     bitToTarget;
        // register bits on the way back during read frames.
        logic     bitToHost;

        modport bridge (
                output frameActive,
                output frameOp,
                output bitValid,
                output bitToTarget,
                input  bitToHost
        );

        modport target (
                input  frameActive,
                input  frameOp,
                input  bitValid,
                input  bitToTarget,
                output bitToHost
        );
endinterface

`default_nettype wire

// ==== rtl/ppBridgePkg.sv ====
`default_nettype none

package ppBridgePkg;

        // serial bus geometry.
        localparam int cmdLenW  = 5;
        localparam int idxW     = 4;
        localparam int wordW    = 32;
        localparam int regCount = 16;
        localparam int idxBits  = 4;

        // frame kinds, taken from command bits 7:6.
        typedef enum logic [1:0] {
                opSetIndex = 2'b00,
                opWrite    = 2'b10,
                opRead     = 2'b11
        } bridgeOpT;

        typedef enum logic [3:0] {
                stIdle      = 4'h0,
                stWaitCmd   = 4'h1,
                stDecode    = 4'h2,
                stIdxHold   = 4'h3,
                stWrCollect = 4'h4,
                stWrByte    = 4'h5,
                stSerial    = 4'h6,
                stRdSerial  = 4'h7,
                stRdServe   = 4'h8,
                stRdByte    = 4'h9
        } parserStateT;

        // one serial frame request, parser to shifter.
        typedef struct packed {
                bridgeOpT             op;
                logic [cmdLenW-1:0]   len;
                logic [idxW-1:0]      idx;
                logic [wordW-1:0]     word;
        } serialJobT;

endpackage

`default_nettype wire
